// File: hdl/jsp_byte_fifo.sv
////////////////////////////////////////////////////////////
// Byte FIFO with valid/ready on both sides and an occupancy
// count. Used for both the receive and transmit directions
////////////////////////////////////////////////////////////

module jsp_byte_fifo (
  input  logic                tck_i,
  input  logic                rst_i,
  input  logic                in_valid_i,   // Push request
  input  jsp_pkg::jsp_data_t  in_data_i,
  output logic                in_ready_o,   // Not full
  output logic                out_valid_o,  // Not empty
  output jsp_pkg::jsp_data_t  out_data_o,   // Head byte, straight from storage
  input  logic                out_ready_i,  // Pop request
  output jsp_pkg::jsp_count_t count_o       // Bytes held
);

  localparam int unsigned         PTR_W    = $clog2(jsp_pkg::FIFO_DEPTH);
  localparam logic [PTR_W-1:0]    PTR_LAST = PTR_W'(jsp_pkg::FIFO_DEPTH - 1);
  localparam jsp_pkg::jsp_count_t FULL_CNT = jsp_pkg::jsp_count_t'(jsp_pkg::FIFO_DEPTH);

  jsp_pkg::jsp_data_t  mem_q [jsp_pkg::FIFO_DEPTH];  // Circular storage
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  jsp_pkg::jsp_count_t count_q;
  logic                push;
  logic                pop;

  assign in_ready_o  = (count_q != FULL_CNT);
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];
  assign count_o     = count_q;

  assign push = in_valid_i && in_ready_o;   // Handshake on the input side
  assign pop  = out_valid_o && out_ready_i; // Handshake on the output side

  // Storage write, no reset on payload
  always_ff @(posedge tck_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;  // Wrap at depth
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Idle or simultaneous push and pop
      endcase
    end
  end

endmodule

// File: hdl/jsp_pkg.sv
////////////////////////////////////////////////////////////
// Shared widths, FIFO depth and FSM state encodings for the
// JTAG serial port. Referenced by scoped name, never imported
////////////////////////////////////////////////////////////

package jsp_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////////////////////////

  localparam int unsigned DATA_W     = 8;  // One transferred byte
  localparam int unsigned COUNT_W    = 4;  // Byte counts, one status nibble each
  localparam int unsigned FIFO_DEPTH = 8;  // Entries per FIFO, a full count of 8 fits in COUNT_W

  typedef logic [DATA_W-1:0]  jsp_data_t;   // Data byte
  typedef logic [COUNT_W-1:0] jsp_count_t;  // Byte count or free space

  ////////////////////////////////////////////////////////////
  // State machines
  ////////////////////////////////////////////////////////////

  // Input direction, PC to host
  typedef enum logic [1:0] {
    WR_IDLE   = 2'd0,  // Waiting for capture
    WR_WAIT   = 2'd1,  // Waiting for the start bit on a multi-device chain
    WR_COUNTS = 2'd2,  // Receiving the count byte
    WR_XFER   = 2'd3   // Receiving data bytes
  } wr_state_t;

  // Output direction, host to PC
  typedef enum logic [1:0] {
    RD_IDLE   = 2'd0,  // Waiting for capture
    RD_COUNTS = 2'd1,  // Shifting out the status byte
    RD_RDACK  = 2'd2,  // First bit of a data byte, FIFO pop happens here
    RD_XFER   = 2'd3   // Remaining bits of a data byte
  } rd_state_t;

endpackage

// File: hdl/jsp_rd_ctrl.sv
////////////////////////////////////////////////////////////
// Output controller. Shifts the status byte and then the
// transmit FIFO bytes out on TDO, LSB first
////////////////////////////////////////////////////////////

module jsp_rd_ctrl (
  input  logic                tck_i,
  input  logic                rst_i,
  input  logic                capture_dr_i,
  input  logic                shift_dr_i,
  input  logic                update_dr_i,
  input  logic                module_select_i,
  input  jsp_pkg::jsp_count_t tx_count_i,  // Bytes waiting in the transmit FIFO
  input  jsp_pkg::jsp_data_t  tx_data_i,   // Transmit FIFO head
  input  jsp_pkg::jsp_count_t rx_count_i,  // Receive FIFO occupancy, for the status byte
  output logic                tx_pop_o,    // Pop strobe to the transmit FIFO
  output logic                module_tdo_o
);

  localparam int unsigned         BIT_W    = $clog2(jsp_pkg::DATA_W);
  localparam logic [BIT_W-1:0]    BIT_LAST = BIT_W'(jsp_pkg::DATA_W - 1);
  localparam jsp_pkg::jsp_count_t DEPTH    = jsp_pkg::jsp_count_t'(jsp_pkg::FIFO_DEPTH);

  jsp_pkg::rd_state_t  state_q;
  jsp_pkg::rd_state_t  state_d;
  logic [BIT_W-1:0]    bit_cnt_q;   // Bits sent of the current byte
  jsp_pkg::jsp_count_t out_cnt_q;   // Transmit bytes left, from capture
  jsp_pkg::jsp_data_t  shift_q;     // Parallel-load output register

  logic               start_scan;
  logic               shift_en;
  logic               byte_end;
  logic               out_zero;
  logic               load_head;   // Reload from the FIFO head at a byte boundary
  jsp_pkg::jsp_data_t status;

  assign start_scan = (state_q == jsp_pkg::RD_IDLE) && module_select_i && capture_dr_i;
  assign shift_en   = shift_dr_i && (state_q != jsp_pkg::RD_IDLE);
  assign byte_end   = shift_en && (bit_cnt_q == BIT_LAST);  // Never in RD_RDACK
  assign out_zero   = (out_cnt_q == '0);
  assign load_head  = byte_end && !out_zero;

  // Bytes available high, free space low
  assign status = {tx_count_i, DEPTH - rx_count_i};

  // Ack the byte just loaded on its first bit
  assign tx_pop_o     = (state_q == jsp_pkg::RD_RDACK) && shift_dr_i && !out_zero;
  assign module_tdo_o = shift_q[0];

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      jsp_pkg::RD_IDLE: begin
        if (start_scan) begin
          state_d = jsp_pkg::RD_COUNTS;
        end
      end
      jsp_pkg::RD_COUNTS: begin
        if (update_dr_i) begin
          state_d = jsp_pkg::RD_IDLE;
        end else if (byte_end) begin
          state_d = jsp_pkg::RD_RDACK;
        end
      end
      jsp_pkg::RD_RDACK: begin
        if (update_dr_i) begin
          state_d = jsp_pkg::RD_IDLE;
        end else if (shift_dr_i) begin
          state_d = jsp_pkg::RD_XFER;  // Held during pause
        end
      end
      jsp_pkg::RD_XFER: begin
        if (update_dr_i) begin
          state_d = jsp_pkg::RD_IDLE;
        end else if (byte_end) begin
          state_d = jsp_pkg::RD_RDACK;
        end
      end
      default: state_d = jsp_pkg::RD_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Counters and TDO register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q   <= jsp_pkg::RD_IDLE;
      bit_cnt_q <= '0;
      out_cnt_q <= '0;
      shift_q   <= '0;  // TDO low out of reset
    end else begin
      state_q <= state_d;
      if (start_scan || byte_end) begin
        bit_cnt_q <= '0;
      end else if (shift_en) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
      if (start_scan) begin
        out_cnt_q <= tx_count_i;  // Snapshot of bytes to send
      end else if ((state_q == jsp_pkg::RD_XFER) && load_head) begin
        out_cnt_q <= out_cnt_q - 1'b1;
      end
      if (start_scan) begin
        shift_q <= status;
      end else if (load_head) begin
        shift_q <= tx_data_i;
      end else if (shift_en) begin
        shift_q <= {1'b0, shift_q[jsp_pkg::DATA_W-1:1]};  // Right shift toward TDO
      end
    end
  end

endmodule

// File: hdl/jsp_top.sv
////////////////////////////////////////////////////////////
// JTAG serial port top. Joins the input and output
// controllers to the receive and transmit byte FIFOs
////////////////////////////////////////////////////////////

module jsp_top #(
  parameter bit MULTI_CHAIN = 1'b1  // Start bit required before the count byte
) (
  // JTAG side
  input  logic               tck_i,
  input  logic               rst_i,
  input  logic               tdi_i,
  input  logic               capture_dr_i,
  input  logic               shift_dr_i,
  input  logic               update_dr_i,
  input  logic               module_select_i,
  output logic               module_tdo_o,
  // Host receive side, PC to host
  output jsp_pkg::jsp_data_t host_rx_data_o,
  output logic               host_rx_valid_o,
  input  logic               host_rx_ready_i,
  // Host transmit side, host to PC
  input  jsp_pkg::jsp_data_t host_tx_data_i,
  input  logic               host_tx_valid_i,
  output logic               host_tx_ready_o
);

  logic                rx_push_valid;  // Write controller into receive FIFO
  jsp_pkg::jsp_data_t  rx_push_data;
  jsp_pkg::jsp_count_t rx_count;       // Receive occupancy, for free space
  jsp_pkg::jsp_count_t tx_count;       // Transmit occupancy, for bytes available
  jsp_pkg::jsp_data_t  tx_head;
  logic                tx_pop;

  jsp_wr_ctrl #(
    .MULTI_CHAIN(MULTI_CHAIN)
  ) u_wr_ctrl (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .tdi_i          (tdi_i),
    .capture_dr_i   (capture_dr_i),
    .shift_dr_i     (shift_dr_i),
    .update_dr_i    (update_dr_i),
    .module_select_i(module_select_i),
    .fifo_count_i   (rx_count),
    .push_valid_o   (rx_push_valid),
    .push_data_o    (rx_push_data)
  );

  jsp_rd_ctrl u_rd_ctrl (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .capture_dr_i   (capture_dr_i),
    .shift_dr_i     (shift_dr_i),
    .update_dr_i    (update_dr_i),
    .module_select_i(module_select_i),
    .tx_count_i     (tx_count),
    .tx_data_i      (tx_head),
    .rx_count_i     (rx_count),
    .tx_pop_o       (tx_pop),
    .module_tdo_o   (module_tdo_o)
  );

  // Write controller pushes only within the captured free space
  jsp_byte_fifo u_rx_fifo (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .in_valid_i (rx_push_valid),
    .in_data_i  (rx_push_data),
    .in_ready_o (),
    .out_valid_o(host_rx_valid_o),
    .out_data_o (host_rx_data_o),
    .out_ready_i(host_rx_ready_i),
    .count_o    (rx_count)
  );

  // Pops are bounded by the captured byte count
  jsp_byte_fifo u_tx_fifo (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .in_valid_i (host_tx_valid_i),
    .in_data_i  (host_tx_data_i),
    .in_ready_o (host_tx_ready_o),
    .out_valid_o(),
    .out_data_o (tx_head),
    .out_ready_i(tx_pop),
    .count_o    (tx_count)
  );

endmodule

// File: hdl/jsp_wr_ctrl.sv
////////////////////////////////////////////////////////////
// Input controller. Deserializes TDI into bytes and pushes
// them into the receive FIFO while the counts allow
////////////////////////////////////////////////////////////

module jsp_wr_ctrl #(
  parameter bit MULTI_CHAIN = 1'b1  // Wait for a start bit of 1 after capture
) (
  input  logic                tck_i,
  input  logic                rst_i,
  input  logic                tdi_i,
  input  logic                capture_dr_i,
  input  logic                shift_dr_i,
  input  logic                update_dr_i,
  input  logic                module_select_i,
  input  jsp_pkg::jsp_count_t fifo_count_i,  // Receive FIFO occupancy
  output logic                push_valid_o,  // Push strobe into the receive FIFO
  output jsp_pkg::jsp_data_t  push_data_o
);

  localparam int unsigned         BIT_W    = $clog2(jsp_pkg::DATA_W);
  localparam logic [BIT_W-1:0]    BIT_LAST = BIT_W'(jsp_pkg::DATA_W - 1);
  localparam jsp_pkg::jsp_count_t DEPTH    = jsp_pkg::jsp_count_t'(jsp_pkg::FIFO_DEPTH);

  jsp_pkg::wr_state_t  state_q;
  jsp_pkg::wr_state_t  state_d;
  logic [BIT_W-1:0]    bit_cnt_q;   // Bits received in the current byte
  jsp_pkg::jsp_data_t  shift_q;     // Deserializer, newest bit at the top
  jsp_pkg::jsp_count_t free_cnt_q;  // Space left in the receive FIFO, from capture
  jsp_pkg::jsp_count_t user_cnt_q;  // Bytes the debugger still intends to send

  logic               start_scan;
  logic               shift_en;
  logic               byte_end;    // Edge that samples the eighth bit
  jsp_pkg::jsp_data_t byte_in;     // Byte including the bit on TDI now

  assign start_scan = (state_q == jsp_pkg::WR_IDLE) && module_select_i && capture_dr_i;
  assign shift_en   = shift_dr_i &&
                      ((state_q == jsp_pkg::WR_COUNTS) || (state_q == jsp_pkg::WR_XFER));
  assign byte_end   = shift_en && (bit_cnt_q == BIT_LAST);
  assign byte_in    = {tdi_i, shift_q[jsp_pkg::DATA_W-1:1]};  // LSB arrives first

  // Push only with room left and bytes still announced
  assign push_valid_o = (state_q == jsp_pkg::WR_XFER) && byte_end &&
                        (free_cnt_q != '0) && (user_cnt_q != '0);
  assign push_data_o  = byte_in;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      jsp_pkg::WR_IDLE: begin
        if (start_scan) begin
          state_d = MULTI_CHAIN ? jsp_pkg::WR_WAIT : jsp_pkg::WR_COUNTS;
        end
      end
      jsp_pkg::WR_WAIT: begin
        if (update_dr_i) begin
          state_d = jsp_pkg::WR_IDLE;
        end else if (shift_dr_i && tdi_i) begin
          state_d = jsp_pkg::WR_COUNTS;  // Start bit seen, padding zeros skipped
        end
      end
      jsp_pkg::WR_COUNTS: begin
        if (update_dr_i) begin
          state_d = jsp_pkg::WR_IDLE;
        end else if (byte_end) begin
          state_d = jsp_pkg::WR_XFER;
        end
      end
      jsp_pkg::WR_XFER: begin
        if (update_dr_i) begin
          state_d = jsp_pkg::WR_IDLE;  // Partial byte is dropped
        end
      end
      default: state_d = jsp_pkg::WR_IDLE;
    endcase
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= jsp_pkg::WR_IDLE;
      bit_cnt_q  <= '0;
      free_cnt_q <= '0;
      user_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      // Bit counter restarts at capture and on every byte boundary
      if (start_scan || byte_end) begin
        bit_cnt_q <= '0;
      end else if (shift_en) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
      if (start_scan) begin
        free_cnt_q <= DEPTH - fifo_count_i;  // Snapshot of free space
      end else if (push_valid_o) begin
        free_cnt_q <= free_cnt_q - 1'b1;
      end
      if ((state_q == jsp_pkg::WR_COUNTS) && byte_end) begin
        user_cnt_q <= byte_in[jsp_pkg::DATA_W-1 -: jsp_pkg::COUNT_W];  // High nibble
      end else if (push_valid_o) begin
        user_cnt_q <= user_cnt_q - 1'b1;
      end
    end
  end

  // Deserializer
  always_ff @(posedge tck_i) begin
    if (shift_en) begin
      shift_q <= byte_in;
    end
  end

endmodule

// File: sim.f
+incdir+tests
hdl/jsp_pkg.sv
hdl/jsp_byte_fifo.sv
hdl/jsp_wr_ctrl.sv
hdl/jsp_rd_ctrl.sv
hdl/jsp_top.sv
tests/tb_jsp_top.sv

// File: tests/tb_jsp_scan.svh
////////////////////////////////////////////////////////////
// JTAG DR scan tasks, LFSR stimulus and reference model.
// Included inside the testbench top module
////////////////////////////////////////////////////////////

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step per bit taken
task automatic rand_byte(output jsp_pkg::jsp_data_t b);
  for (int i = 0; i < jsp_pkg::DATA_W; i++) begin
    lfsr_q = lfsr_step(lfsr_q);
    b[i]   = lfsr_q[0];
  end
endtask

// One shift cycle, TDO recorded before the shifting edge
task automatic shift_bit(input logic b);
  @(negedge tck_i);
  capture_dr_i = 1'b0;
  shift_dr_i   = 1'b1;
  tdi_i        = b;
  tdo_bits_q.push_back(module_tdo_o);
endtask

////////////////////////////////////////////////////////////
// DR scan: capture, padding, start bit, count byte, data
////////////////////////////////////////////////////////////

task automatic run_scan(input int pad_n, input jsp_pkg::jsp_data_t count_byte,
                        input int bits_n);
  logic bits_q[$];
  tdo_bits_q.delete();
  repeat (pad_n) bits_q.push_back(1'b0);  // Zeros from devices ahead on the chain
  bits_q.push_back(1'b1);                 // Start bit
  for (int i = 0; i < jsp_pkg::DATA_W; i++) bits_q.push_back(count_byte[i]);
  foreach (scan_data_q[j]) begin
    for (int i = 0; i < jsp_pkg::DATA_W; i++) bits_q.push_back(scan_data_q[j][i]);  // LSB first
  end
  @(negedge tck_i);
  module_select_i = 1'b1;
  capture_dr_i    = 1'b1;
  for (int i = 0; i < bits_n; i++) shift_bit(bits_q[i]);  // Stops early on an abort
  @(negedge tck_i);
  shift_dr_i  = 1'b0;
  tdi_i       = 1'b0;
  update_dr_i = 1'b1;
  @(negedge tck_i);
  update_dr_i     = 1'b0;
  module_select_i = 1'b0;
endtask

// Byte idx of the recorded TDO stream, byte 0 is the status
function automatic jsp_pkg::jsp_data_t tdo_byte(input int idx);
  jsp_pkg::jsp_data_t b;
  for (int i = 0; i < jsp_pkg::DATA_W; i++) b[i] = tdo_bits_q[idx * jsp_pkg::DATA_W + i];
  return b;
endfunction

// Expected status, accepted bytes and TDO data bytes of one scan
function automatic void ref_scan(input int tx_occ, input int rx_occ, input int pad_n,
                                 input jsp_pkg::jsp_data_t count_byte, input int data_n,
                                 input int bits_n, output jsp_pkg::jsp_data_t status,
                                 output int accepted, output int tdo_n);
  int free_n;
  int done_n;
  free_n   = jsp_pkg::FIFO_DEPTH - rx_occ;
  done_n   = (bits_n >= pad_n + 9) ? (bits_n - pad_n - 9) / 8 : 0;  // Complete data bytes
  done_n   = (done_n > data_n) ? data_n : done_n;
  status   = {jsp_pkg::jsp_count_t'(tx_occ), jsp_pkg::jsp_count_t'(free_n)};
  accepted = (count_byte[7:4] < free_n) ? count_byte[7:4] : free_n;  // Announced vs room
  accepted = (done_n < accepted) ? done_n : accepted;
  tdo_n    = ((bits_n - 8) / 8 < tx_occ) ? (bits_n - 8) / 8 : tx_occ;
endfunction

// File: tests/tb_jsp_top.sv
////////////////////////////////////////////////////////////
// Testbench for the JTAG serial port. Runs DR scans on the
// DUT and checks TDO and host-side bytes against a model
////////////////////////////////////////////////////////////

module tb_jsp_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_CYCLES = 4000;  // Limit on the whole run in tck cycles

  logic               tck_i;
  logic               rst_i;
  logic               tdi_i;
  logic               capture_dr_i;
  logic               shift_dr_i;
  logic               update_dr_i;
  logic               module_select_i;
  logic               module_tdo_o;
  logic               host_rx_valid_o;
  logic               host_rx_ready_i;
  logic               host_tx_valid_i;
  logic               host_tx_ready_o;
  jsp_pkg::jsp_data_t host_rx_data_o;
  jsp_pkg::jsp_data_t host_tx_data_i;

  logic [31:0]        lfsr_q;
  logic               tdo_bits_q[$];   // TDO of the last scan
  jsp_pkg::jsp_data_t scan_data_q[$];  // Data bytes of the next scan
  jsp_pkg::jsp_data_t exp_rx_q[$];     // Model of the receive FIFO
  jsp_pkg::jsp_data_t tx_model_q[$];   // Model of the transmit FIFO
  int                 cycle_cnt = 0;

  `include "tb_jsp_scan.svh"

  jsp_top #(.MULTI_CHAIN(1'b1)) u_jsp_top (.*);

  always #20 tck_i = ~tck_i;  // 40 ns period

  ////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input jsp_pkg::jsp_data_t got_v,
                            input jsp_pkg::jsp_data_t exp_v);
    if (got_v !== exp_v) begin
      report_failure($sformatf("mismatch at %0d ns: %s got 0x%02h expected 0x%02h",
                               $time, name, got_v, exp_v));
    end
  endtask

  task automatic check_count(input string name, input jsp_pkg::jsp_count_t got_v,
                             input jsp_pkg::jsp_count_t exp_v);
    if (got_v !== exp_v) begin
      report_failure($sformatf("mismatch at %0d ns: %s got %0d expected %0d",
                               $time, name, got_v, exp_v));
    end
  endtask

  task automatic check_flag(input string name, input logic got_v, input logic exp_v);
    if (got_v !== exp_v) begin
      report_failure($sformatf("mismatch at %0d ns: %s got %b expected %b",
                               $time, name, got_v, exp_v));
    end
  endtask

  // Scan with model update, status and TDO data checks
  task automatic scan_and_check(input int pad_n, input jsp_pkg::jsp_data_t count_byte,
                                input int bits_n);
    jsp_pkg::jsp_data_t exp_status;
    jsp_pkg::jsp_data_t got_status;
    int                 accepted;
    int                 tdo_n;
    int                 full_n;
    full_n = pad_n + 9 + 8 * scan_data_q.size();
    bits_n = (bits_n < 0 || bits_n > full_n) ? full_n : bits_n;  // Negative means whole scan
    ref_scan(tx_model_q.size(), exp_rx_q.size(), pad_n, count_byte, scan_data_q.size(),
             bits_n, exp_status, accepted, tdo_n);
    for (int j = 0; j < accepted; j++) exp_rx_q.push_back(scan_data_q[j]);
    run_scan(pad_n, count_byte, bits_n);
    got_status = tdo_byte(0);
    check_count("status bytes available", got_status[7:4], exp_status[7:4]);
    check_count("status free space", got_status[3:0], exp_status[3:0]);
    for (int j = 0; j < tdo_n; j++) begin
      check_data("module_tdo_o byte", tdo_byte(j + 1), tx_model_q.pop_front());
    end
  endtask

  // Host pushes one byte into the transmit side
  task automatic push_tx(input jsp_pkg::jsp_data_t b);
    @(negedge tck_i);
    host_tx_valid_i = 1'b1;
    host_tx_data_i  = b;
    while (!host_tx_ready_o) @(negedge tck_i);
    @(negedge tck_i);  // Moved on the edge just passed
    host_tx_valid_i = 1'b0;
    tx_model_q.push_back(b);
  endtask

  task automatic load_random_data(input int n);
    jsp_pkg::jsp_data_t b;
    scan_data_q.delete();
    repeat (n) begin
      rand_byte(b);
      scan_data_q.push_back(b);
    end
  endtask

  task automatic wait_rx_drained();
    while (exp_rx_q.size() != 0) @(negedge tck_i);
    check_flag("host_rx_valid_o", host_rx_valid_o, 1'b0);  // Nothing extra behind them
  endtask

  // Receive side compare on the edge where a byte moves
  always @(posedge tck_i) begin
    if (!rst_i && host_rx_valid_o && host_rx_ready_i) begin
      if (exp_rx_q.size() == 0) begin
        report_failure("receive FIFO delivered a byte that no scan should have accepted");
      end else begin
        check_data("host_rx_data_o", host_rx_data_o, exp_rx_q.pop_front());
      end
    end
  end

  always @(posedge tck_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) report_failure("timeout, the run did not finish in time");
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    jsp_pkg::jsp_data_t b;
    tck_i = 1'b0;
    rst_i = 1'b1;
    {tdi_i, capture_dr_i, shift_dr_i, update_dr_i, module_select_i} = '0;
    {host_tx_valid_i, host_tx_data_i} = '0;
    host_rx_ready_i = 1'b1;
    lfsr_q = 32'h49488663;
    repeat (3) @(negedge tck_i);
    rst_i = 1'b0;
    check_flag("host_rx_valid_o", host_rx_valid_o, 1'b0);
    check_flag("host_tx_ready_o", host_tx_ready_o, 1'b1);
    check_flag("module_tdo_o", module_tdo_o, 1'b0);
    // Fill the transmit FIFO, then read it all out after the status byte
    repeat (jsp_pkg::FIFO_DEPTH) begin
      rand_byte(b);
      push_tx(b);
    end
    check_flag("host_tx_ready_o", host_tx_ready_o, 1'b0);
    scan_data_q = {8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
    scan_and_check(2, 8'h00, -1);
    check_flag("host_tx_ready_o", host_tx_ready_o, 1'b1);
    // Write path with leading zeros before the start bit
    load_random_data(3);
    scan_and_check(5, 8'h30, -1);
    wait_rx_drained();
    // Free-space limit with the host stalled
    host_rx_ready_i = 1'b0;
    load_random_data(6);
    scan_and_check(1, 8'h60, -1);
    load_random_data(5);
    scan_and_check(3, 8'h50, -1);  // Only two fit
    scan_data_q.delete();
    scan_and_check(0, 8'h00, -1);  // Free nibble now 0
    host_rx_ready_i = 1'b1;
    wait_rx_drained();
    // Update in the middle of the second data byte
    load_random_data(2);
    scan_and_check(1, 8'h20, 21);
    wait_rx_drained();
    load_random_data(1);
    scan_and_check(2, 8'h10, -1);
    wait_rx_drained();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
